// File: include/spw_rx_defs.svh
// Character widths of the SpaceWire receive path
// Control codes as {flag, c1, c0} and the EOP/EEP data-flag words

`ifndef SPW_RX_DEFS_SVH
`define SPW_RX_DEFS_SVH

// Body bits of a data character
`define SPW_DATA_BITS 8
// Body bits of a control character
`define SPW_CTRL_BITS 2

// Control codes with the flag bit on top
`define SPW_CODE_FCT 3'd4
`define SPW_CODE_EOP 3'd5
`define SPW_CODE_EEP 3'd6
`define SPW_CODE_ESC 3'd7

// Words written to the receive buffer for packet ends
`define SPW_FLAG_EOP 9'd256
`define SPW_FLAG_EEP 9'd257

`endif

// File: hw/spw_char_pkg.sv
// Vector types for SpaceWire characters
// Control code, received data word, time code and raw body

`include "spw_rx_defs.svh"

package spw_char_pkg;

	// --------------------------------------------------
	// Character level types
	// --------------------------------------------------

	// Flag bit plus the two control bits
	typedef logic [`SPW_CTRL_BITS:0] ctrl_code_t;

	// Bit 8 marks EOP or EEP, low bits carry the data byte
	typedef logic [`SPW_DATA_BITS:0] data_flag_t;

	// Time code value sent after an ESC
	typedef logic [`SPW_DATA_BITS-1:0] time_code_t;

	// Body as shifted in, a zero on top of the data byte
	typedef logic [`SPW_DATA_BITS:0] char_payload_t;

endpackage

// File: hw/spw_rx_pkg.sv
// State encodings of the receive path
// Receiver FSM and character assembler FSM

package spw_rx_pkg;

	// Receiver alternates between a body and the next parity
	typedef enum logic [0:0] {
		RX_WAIT_CHAR   = 1'b0,
		RX_WAIT_PARITY = 1'b1
	} rx_state_t;

	// Assembler walks parity, flag, then the body bits
	typedef enum logic [1:0] {
		ASM_PARITY = 2'd0,
		ASM_FLAG   = 2'd1,
		ASM_BODY   = 2'd2
	} asm_state_t;

endpackage

// File: hw/spw_char_if.sv
// Character bus from the assembler to the receiver
// Completion pulses, parity pairs, control codes and the body

`timescale 1ns/1ps

interface spw_char_if;

	// Body of a control or data character is complete
	logic ready_control_p_r;
	logic ready_data_p_r;

	// Parity and flag of the following character are in
	logic ready_control;
	logic ready_data;

	// Received parity bit, split by previous character type
	logic parity_rec_c;
	logic parity_rec_d;

	// Expected parity from the running count
	logic parity_rec_c_gen;
	logic parity_rec_d_gen;

	// Current and previous codes
	spw_char_pkg::ctrl_code_t    control_p_r;
	spw_char_pkg::ctrl_code_t    control_l_r;
	spw_char_pkg::char_payload_t dta_timec_p;

	modport assembler (
		output ready_control_p_r, ready_data_p_r, ready_control, ready_data,
		output parity_rec_c, parity_rec_d, parity_rec_c_gen, parity_rec_d_gen,
		output control_p_r, control_l_r, dta_timec_p
	);

	modport receiver (
		input ready_control_p_r, ready_data_p_r, ready_control, ready_data,
		input parity_rec_c, parity_rec_d, parity_rec_c_gen, parity_rec_d_gen,
		input control_p_r, control_l_r, dta_timec_p
	);

endinterface

// File: hw/rx_ds_decoder.sv
// Data/strobe line decoder
// Two-flop synchronizers, change detect on data XOR strobe,
// bit value and one-cycle bit strobe out

`timescale 1ns/1ps

module rx_ds_decoder (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic d_in,
	input  logic s_in,
	output logic bit_value,
	output logic bit_strobe
);

	// Synchronizer chains, index 1 is the settled copy
	logic [1:0] d_sync;
	logic [1:0] s_sync;

	// Line state one stage after the synchronizer
	logic       data_q;
	logic       xor_q;
	logic       xor_prev;

	// --------------------------------------------------
	// Synchronize and track the DS state
	// --------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			d_sync   <= 2'b00;
			s_sync   <= 2'b00;
			data_q   <= 1'b0;
			xor_q    <= 1'b0;
			xor_prev <= 1'b0;
		end
		else
		begin
			d_sync   <= {d_sync[0], d_in};
			s_sync   <= {s_sync[0], s_in};
			// Each new bit flips data XOR strobe
			data_q   <= d_sync[1];
			xor_q    <= d_sync[1] ^ s_sync[1];
			xor_prev <= xor_q;
		end
	end

	// --------------------------------------------------
	// Bit recovery
	// --------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			bit_value  <= 1'b0;
			bit_strobe <= 1'b0;
		end
		else
		begin
			bit_strobe <= xor_q ^ xor_prev;
			// Hold the last value between strobes
			if (xor_q ^ xor_prev)
			begin
				bit_value <= data_q;
			end
		end
	end

endmodule

// File: hw/rx_char_assembler.sv
// Character assembler
// Parity, flag and body bit FSM, running odd parity,
// current and previous control code tracking

`timescale 1ns/1ps

`include "spw_rx_defs.svh"

module rx_char_assembler (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic bit_value,
	input  logic bit_strobe,
	spw_char_if.assembler char_bus
);

	spw_rx_pkg::asm_state_t           state;
	// Body bits left after the current one
	logic [2:0]                       bit_cnt;
	// Flag of the character in progress
	logic                             flag_q;
	// Type of the last complete character
	logic                             prev_ctrl;
	// XOR of the body bits so far
	logic                             body_par;
	logic [`SPW_DATA_BITS-1:0]        body_q;
	logic [`SPW_DATA_BITS-1:0]        body_next;

	// LSB arrives first, so shift in from the top
	assign body_next = {bit_value, body_q[`SPW_DATA_BITS-1:1]};

	// --------------------------------------------------
	// Assembler FSM
	// --------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state                      <= spw_rx_pkg::ASM_PARITY;
			bit_cnt                    <= 3'd0;
			flag_q                     <= 1'b0;
			prev_ctrl                  <= 1'b0;
			body_par                   <= 1'b0;
			body_q                     <= '0;
			char_bus.ready_control_p_r <= 1'b0;
			char_bus.ready_data_p_r    <= 1'b0;
			char_bus.ready_control     <= 1'b0;
			char_bus.ready_data        <= 1'b0;
			char_bus.parity_rec_c      <= 1'b0;
			char_bus.parity_rec_d      <= 1'b0;
			char_bus.parity_rec_c_gen  <= 1'b0;
			char_bus.parity_rec_d_gen  <= 1'b0;
			char_bus.control_p_r       <= '0;
			char_bus.control_l_r       <= '0;
			char_bus.dta_timec_p       <= '0;
		end
		else
		begin
			// All ready signals are single-cycle
			char_bus.ready_control_p_r <= 1'b0;
			char_bus.ready_data_p_r    <= 1'b0;
			char_bus.ready_control     <= 1'b0;
			char_bus.ready_data        <= 1'b0;

			if (bit_strobe)
			begin
				case (state)
				spw_rx_pkg::ASM_PARITY:
				begin
					// Parity belongs to the previous character
					if (prev_ctrl)
						char_bus.parity_rec_c <= bit_value;
					else
						char_bus.parity_rec_d <= bit_value;
					state <= spw_rx_pkg::ASM_FLAG;
				end
				spw_rx_pkg::ASM_FLAG:
				begin
					flag_q   <= bit_value;
					body_par <= 1'b0;
					// Odd parity over previous body and this flag
					if (prev_ctrl)
					begin
						char_bus.parity_rec_c_gen <= ~(body_par ^ bit_value);
						char_bus.ready_control    <= 1'b1;
					end
					else
					begin
						char_bus.parity_rec_d_gen <= ~(body_par ^ bit_value);
						char_bus.ready_data       <= 1'b1;
					end
					if (bit_value)
						bit_cnt <= 3'(`SPW_CTRL_BITS - 1);
					else
						bit_cnt <= 3'(`SPW_DATA_BITS - 1);
					state <= spw_rx_pkg::ASM_BODY;
				end
				spw_rx_pkg::ASM_BODY:
				begin
					body_q   <= body_next;
					body_par <= body_par ^ bit_value;
					bit_cnt  <= bit_cnt - 3'd1;
					if (bit_cnt == 3'd0)
					begin
						// Character done, older code moves down
						prev_ctrl            <= flag_q;
						char_bus.control_l_r <= char_bus.control_p_r;
						if (flag_q)
						begin
							char_bus.control_p_r <=
								{1'b1, body_next[`SPW_DATA_BITS-1 -: `SPW_CTRL_BITS]};
							char_bus.ready_control_p_r <= 1'b1;
						end
						else
						begin
							// Data clears the code, flag stays 0
							char_bus.control_p_r    <= '0;
							char_bus.dta_timec_p    <= {1'b0, body_next};
							char_bus.ready_data_p_r <= 1'b1;
						end
						state <= spw_rx_pkg::ASM_PARITY;
					end
				end
				default:
				begin
					state <= spw_rx_pkg::ASM_PARITY;
				end
				endcase
			end
		end
	end

endmodule

// File: hw/rx_data_receive.sv
// Character classifier of the receive path
// Data and EOP/EEP words, time codes, FCT pulses,
// sticky parity errors per character type

`timescale 1ns/1ps

`include "spw_rx_defs.svh"

module rx_data_receive (
	input  logic                       posedge_clk,
	input  logic                       rx_resetn,
	spw_char_if.receiver               char_bus,
	output spw_rx_pkg::rx_state_t      state_data_process,
	output logic                       last_is_control,
	output logic                       last_is_data,
	output logic                       last_is_timec,
	output logic                       rx_error_c,
	output logic                       rx_error_d,
	output logic                       rx_got_fct,
	output logic                       rx_buffer_write,
	output spw_char_pkg::data_flag_t   rx_data_flag,
	output spw_char_pkg::time_code_t   timecode
);

	spw_rx_pkg::rx_state_t next_state;
	// Previous character was an ESC
	logic                  after_esc;

	assign after_esc = (char_bus.control_l_r == `SPW_CODE_ESC);

	// --------------------------------------------------
	// Next state
	// --------------------------------------------------
	always_comb
	begin
		next_state = state_data_process;
		case (state_data_process)
		spw_rx_pkg::RX_WAIT_CHAR:
		begin
			if (char_bus.ready_control_p_r || char_bus.ready_data_p_r)
				next_state = spw_rx_pkg::RX_WAIT_PARITY;
		end
		spw_rx_pkg::RX_WAIT_PARITY:
		begin
			// Next parity closes the previous character
			if (char_bus.ready_control || char_bus.ready_data)
				next_state = spw_rx_pkg::RX_WAIT_CHAR;
		end
		default:
		begin
			next_state = spw_rx_pkg::RX_WAIT_CHAR;
		end
		endcase
	end

	// --------------------------------------------------
	// Outputs
	// --------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state_data_process <= spw_rx_pkg::RX_WAIT_CHAR;
			last_is_control    <= 1'b0;
			last_is_data       <= 1'b0;
			last_is_timec      <= 1'b0;
			rx_error_c         <= 1'b0;
			rx_error_d         <= 1'b0;
			rx_got_fct         <= 1'b0;
			rx_buffer_write    <= 1'b0;
			rx_data_flag       <= '0;
			timecode           <= '0;
		end
		else
		begin
			state_data_process <= next_state;
			// Pulses default low
			rx_got_fct         <= 1'b0;
			rx_buffer_write    <= 1'b0;

			case (state_data_process)
			spw_rx_pkg::RX_WAIT_CHAR:
			begin
				if (char_bus.ready_control_p_r)
				begin
					last_is_control <= 1'b1;
					last_is_data    <= 1'b0;
					last_is_timec   <= 1'b0;
					// ESC followed by FCT is a NULL
					if (char_bus.control_p_r == `SPW_CODE_FCT && !after_esc)
						rx_got_fct <= 1'b1;
					if (char_bus.control_p_r == `SPW_CODE_EOP)
					begin
						rx_data_flag    <= `SPW_FLAG_EOP;
						rx_buffer_write <= 1'b1;
					end
					else if (char_bus.control_p_r == `SPW_CODE_EEP)
					begin
						rx_data_flag    <= `SPW_FLAG_EEP;
						rx_buffer_write <= 1'b1;
					end
				end
				else if (char_bus.ready_data_p_r)
				begin
					last_is_control <= 1'b0;
					if (after_esc)
					begin
						// ESC plus data carries a time code
						timecode      <= char_bus.dta_timec_p[`SPW_DATA_BITS-1:0];
						last_is_data  <= 1'b0;
						last_is_timec <= 1'b1;
					end
					else
					begin
						rx_data_flag    <= char_bus.dta_timec_p;
						rx_buffer_write <= 1'b1;
						last_is_data    <= 1'b1;
						last_is_timec   <= 1'b0;
					end
				end
			end
			spw_rx_pkg::RX_WAIT_PARITY:
			begin
				// Errors latch until reset
				if (char_bus.ready_control)
				begin
					if (char_bus.parity_rec_c != char_bus.parity_rec_c_gen)
						rx_error_c <= 1'b1;
				end
				else if (char_bus.ready_data)
				begin
					if (char_bus.parity_rec_d != char_bus.parity_rec_d_gen)
						rx_error_d <= 1'b1;
				end
			end
			default:
			begin
				state_data_process <= spw_rx_pkg::RX_WAIT_CHAR;
			end
			endcase
		end
	end

endmodule

// File: hw/spw_rx_top.sv
// Receive path top level
// DS decoder, character assembler and classifier

`timescale 1ns/1ps

module spw_rx_top (
	input  logic                     posedge_clk,
	input  logic                     rx_resetn,
	input  logic                     d_in,
	input  logic                     s_in,
	output logic                     last_is_control,
	output logic                     last_is_data,
	output logic                     last_is_timec,
	output logic                     rx_error_c,
	output logic                     rx_error_d,
	output logic                     rx_got_fct,
	output logic                     rx_buffer_write,
	output spw_char_pkg::data_flag_t rx_data_flag,
	output spw_char_pkg::time_code_t timecode
);

	// Decoded bit stream
	logic bit_value;
	logic bit_strobe;
	// Classifier state, internal only
	spw_rx_pkg::rx_state_t state_data_process;

	// Character bus between assembler and classifier
	spw_char_if char_bus ();

	rx_ds_decoder rx_ds_decoder_i (
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.d_in        (d_in),
		.s_in        (s_in),
		.bit_value   (bit_value),
		.bit_strobe  (bit_strobe)
	);

	rx_char_assembler rx_char_assembler_i (
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.bit_value   (bit_value),
		.bit_strobe  (bit_strobe),
		.char_bus    (char_bus.assembler)
	);

	rx_data_receive rx_data_receive_i (
		.posedge_clk        (posedge_clk),
		.rx_resetn          (rx_resetn),
		.char_bus           (char_bus.receiver),
		.state_data_process (state_data_process),
		.last_is_control    (last_is_control),
		.last_is_data       (last_is_data),
		.last_is_timec      (last_is_timec),
		.rx_error_c         (rx_error_c),
		.rx_error_d         (rx_error_d),
		.rx_got_fct         (rx_got_fct),
		.rx_buffer_write    (rx_buffer_write),
		.rx_data_flag       (rx_data_flag),
		.timecode           (timecode)
	);

endmodule

// File: tests/spw_rx_checker.sv
// Output checker for the SpaceWire receive path
// Expected event queue, per-event compares, pulse counts,
// sticky error check and summary line

`timescale 1ns/1ps

module spw_rx_checker (
	input  logic                     posedge_clk,
	input  logic                     rx_resetn,
	input  logic                     last_is_control,
	input  logic                     last_is_data,
	input  logic                     last_is_timec,
	input  logic                     rx_error_c,
	input  logic                     rx_error_d,
	input  logic                     rx_got_fct,
	input  logic                     rx_buffer_write,
	input  spw_char_pkg::data_flag_t rx_data_flag,
	input  spw_char_pkg::time_code_t timecode,
	input  logic                     exp_push,
	input  logic [11:0]              exp_event,
	input  logic                     stim_done,
	output logic                     check_done,
	output int                       fail_count
);

	// Event kinds in exp_event[11:9]
	localparam logic [2:0] EV_DATA  = 3'd0;
	localparam logic [2:0] EV_TIMEC = 3'd1;
	localparam logic [2:0] EV_ERR_D = 3'd2;
	localparam logic [2:0] EV_ERR_C = 3'd3;
	localparam logic [2:0] EV_FCT   = 3'd4;
	localparam logic [2:0] EV_PEND  = 3'd5;

	logic [11:0] exp_q[$];
	logic [11:0] ev;
	logic [7:0]  old_tc;
	// Error flags as they were when the event was taken
	logic        err_c_before;
	logic        err_d_before;
	logic        err_c_exp;
	logic        err_d_exp;
	int          pass_count;
	int          writes_seen = 0;
	int          fcts_seen = 0;
	int          writes_exp;
	int          fcts_exp;
	int          cnt;
	int          test_no;
	string       name;

	// Has the DUT produced the output this event waits for
	function automatic logic awaited(input logic [11:0] e, input logic [7:0] tc_before);
		case (e[11:9])
		EV_TIMEC: return timecode != tc_before;
		EV_ERR_D: return rx_error_d;
		EV_ERR_C: return rx_error_c;
		EV_FCT:   return rx_got_fct;
		default:  return rx_buffer_write;
		endcase
	endfunction

	// Type flag on top, value below
	// Error events carry the flag state before the bad parity in bit 1
	function automatic logic [9:0] observed(input logic [2:0] kind);
		case (kind)
		EV_DATA:  return {last_is_data, rx_data_flag};
		EV_TIMEC: return {last_is_timec, 1'b0, timecode};
		EV_ERR_D: return {rx_error_d, 7'd0, err_d_before, rx_error_c};
		EV_ERR_C: return {rx_error_c, 7'd0, err_c_before, rx_error_d};
		EV_FCT:   return {last_is_control, 8'd0, rx_got_fct};
		default:  return {last_is_control, rx_data_flag};
		endcase
	endfunction

	function automatic string kind_name(input logic [2:0] kind);
		case (kind)
		EV_DATA:  return "data";
		EV_TIMEC: return "timecode";
		EV_ERR_D: return "parity_after_data";
		EV_ERR_C: return "parity_after_control";
		EV_FCT:   return "fct";
		default:  return "packet_end";
		endcase
	endfunction

	task automatic compare(input string test, input int expected, input int actual);
		if (expected == actual)
		begin
			pass_count++;
			$display("Pass  %s: %0h", test, actual);
		end
		else
		begin
			fail_count++;
			$display("Error %s: expected %0h, actual %0h", test, expected, actual);
		end
	endtask

	always @(posedge posedge_clk)
	begin
		if (exp_push)
			exp_q.push_back(exp_event);
	end

	// Every pulse counts, spurious ones show up in the totals
	always @(negedge posedge_clk)
	begin
		if (rx_buffer_write)
			writes_seen++;
		if (rx_got_fct)
			fcts_seen++;
	end

	// --------------------------------------------------
	// Event checking
	// --------------------------------------------------
	initial
	begin
		check_done   = 1'b0;
		fail_count   = 0;
		pass_count   = 0;
		writes_exp   = 0;
		fcts_exp     = 0;
		err_c_exp    = 1'b0;
		err_d_exp    = 1'b0;
		err_c_before = 1'b0;
		err_d_before = 1'b0;
		test_no      = 0;
		cnt          = 0;
		@(negedge posedge_clk);
		while (!rx_resetn && cnt < 1000)
		begin
			@(negedge posedge_clk);
			cnt++;
		end
		if (!rx_resetn)
		begin
			fail_count++;
			$display("Reset was never released");
		end
		@(negedge posedge_clk);
		compare("reset_values", 0, {last_is_control, last_is_data, last_is_timec, rx_error_c,
			rx_error_d, rx_got_fct, rx_buffer_write, rx_data_flag, timecode});
		cnt = 0;
		while (!(stim_done && exp_q.size() == 0) && cnt < 2000)
		begin
			if (exp_q.size() == 0)
			begin
				@(negedge posedge_clk);
				cnt++;
			end
			else
			begin
				ev           = exp_q.pop_front();
				old_tc       = timecode;
				err_c_before = rx_error_c;
				err_d_before = rx_error_d;
				test_no++;
				name    = $sformatf("%s_%0d", kind_name(ev[11:9]), test_no);
				cnt     = 0;
				while (!awaited(ev, old_tc) && cnt < 200)
				begin
					@(negedge posedge_clk);
					cnt++;
				end
				if (!awaited(ev, old_tc))
				begin
					fail_count++;
					$display("%s: DUT output did not respond within 200 cycles", name);
				end
				else
					compare(name, {1'b1, ev[8:0]}, observed(ev[11:9]));
				if (ev[11:9] == EV_DATA || ev[11:9] == EV_PEND)
					writes_exp++;
				if (ev[11:9] == EV_FCT)
					fcts_exp++;
				if (ev[11:9] == EV_ERR_C)
					err_c_exp = 1'b1;
				if (ev[11:9] == EV_ERR_D)
					err_d_exp = 1'b1;
				// Step past the pulse just matched
				@(negedge posedge_clk);
				cnt = 0;
			end
		end
		if (cnt >= 2000)
		begin
			fail_count++;
			$display("No expected event arrived within 2000 cycles");
		end
		compare("write_count", writes_exp, writes_seen);
		compare("fct_count", fcts_exp, fcts_seen);
		// Both errors hold until reset
		compare("sticky_errors", {err_c_exp, err_d_exp}, {rx_error_c, rx_error_d});
		$display("Checks: %0d passed, %0d failed", pass_count, fail_count);
		check_done = 1'b1;
	end

endmodule

// File: tests/tb_spw_rx.sv
// Testbench top for the SpaceWire receive path
// Clock, reset, DS line driver, random character stream,
// reference model for parity and expected events

`timescale 1ns/1ps

`include "spw_rx_defs.svh"

module tb_spw_rx;

	// Event kinds in exp_event[11:9], same codes as in the checker
	localparam logic [2:0] EV_DATA  = 3'd0;
	localparam logic [2:0] EV_TIMEC = 3'd1;
	localparam logic [2:0] EV_ERR_D = 3'd2;
	localparam logic [2:0] EV_ERR_C = 3'd3;
	localparam logic [2:0] EV_FCT   = 3'd4;
	localparam logic [2:0] EV_PEND  = 3'd5;

	logic                     posedge_clk;
	logic                     rx_resetn;
	logic                     d_in;
	logic                     s_in;
	logic                     last_is_control;
	logic                     last_is_data;
	logic                     last_is_timec;
	logic                     rx_error_c;
	logic                     rx_error_d;
	logic                     rx_got_fct;
	logic                     rx_buffer_write;
	spw_char_pkg::data_flag_t rx_data_flag;
	spw_char_pkg::time_code_t timecode;
	// Expected event channel to the checker
	logic                     exp_push;
	logic [11:0]              exp_event;
	logic                     stim_done;
	logic                     check_done;
	int                       fail_count;
	// Reference model state
	integer                   seed;
	logic                     body_par;
	logic                     prev_ctrl;
	logic                     err_d_done;
	logic                     err_c_done;
	logic [7:0]               last_tc;
	logic [7:0]               rand_byte;
	int                       char_idx;
	int                       pick;
	int                       k;
	int                       wait_cycles;

	spw_rx_top spw_rx_top_i (.*);

	spw_rx_checker spw_rx_checker_i (.*);

	initial
	begin
		posedge_clk = 1'b0;
		forever #4 posedge_clk = ~posedge_clk;
	end

	// --------------------------------------------------
	// DS line driver
	// --------------------------------------------------

	// Called on a falling edge, holds each bit for 6 clocks
	task automatic send_bit(input logic b);
		// Strobe toggles when data repeats
		if (b == d_in)
			s_in = ~s_in;
		else
			d_in = b;
		@(negedge posedge_clk);
		exp_push = 1'b0;
		repeat (5) @(negedge posedge_clk);
	endtask

	task automatic send_char(input logic flag, input logic [7:0] body, input logic report,
		input logic [11:0] ev);
		int   n;
		int   i;
		logic corrupt;
		n       = flag ? `SPW_CTRL_BITS : `SPW_DATA_BITS;
		corrupt = 1'b0;
		// One bad parity per type, error type follows the previous character
		if (char_idx >= 20 && !prev_ctrl && !err_d_done)
		begin
			corrupt    = 1'b1;
			exp_event  = {EV_ERR_D, 8'd0, err_c_done};
			err_d_done = 1'b1;
		end
		else if (char_idx >= 40 && prev_ctrl && !err_c_done)
		begin
			corrupt    = 1'b1;
			exp_event  = {EV_ERR_C, 8'd0, err_d_done};
			err_c_done = 1'b1;
		end
		// Odd parity over previous body plus this flag
		send_bit(~(body_par ^ flag) ^ corrupt);
		exp_push = corrupt;
		send_bit(flag);
		body_par = 1'b0;
		// Body goes out LSB first
		for (i = 0; i < n; i = i + 1)
		begin
			if (i == n - 1 && report)
			begin
				exp_event = ev;
				exp_push  = 1'b1;
			end
			send_bit(body[i]);
			body_par = body_par ^ body[i];
		end
		prev_ctrl = flag;
		char_idx  = char_idx + 1;
	endtask

	task automatic send_ctrl(input logic [2:0] code, input logic report, input logic [11:0] ev);
		send_char(1'b1, {6'd0, code[1:0]}, report, ev);
	endtask

	// ESC then FCT, nothing visible expected
	task automatic send_null();
		send_ctrl(`SPW_CODE_ESC, 1'b0, 12'd0);
		send_ctrl(`SPW_CODE_FCT, 1'b0, 12'd0);
	endtask

	// --------------------------------------------------
	// Random character stream
	// --------------------------------------------------
	initial
	begin
		seed       = 24;
		rx_resetn  = 1'b0;
		d_in       = 1'b0;
		s_in       = 1'b0;
		exp_push   = 1'b0;
		exp_event  = 12'd0;
		stim_done  = 1'b0;
		body_par   = 1'b0;
		prev_ctrl  = 1'b0;
		err_d_done = 1'b0;
		err_c_done = 1'b0;
		last_tc    = 8'd0;
		char_idx   = 0;
		repeat (16) @(negedge posedge_clk);
		rx_resetn = 1'b1;
		repeat (20) @(negedge posedge_clk);
		send_null();
		for (k = 0; k < 60; k = k + 1)
		begin
			pick      = {$random(seed)} % 6;
			rand_byte = $random(seed);
			case (pick)
			0: send_char(1'b0, rand_byte, 1'b1, {EV_DATA, 1'b0, rand_byte});
			1: send_ctrl(`SPW_CODE_FCT, 1'b1, {EV_FCT, 9'd1});
			2: send_ctrl(`SPW_CODE_EOP, 1'b1, {EV_PEND, `SPW_FLAG_EOP});
			3: send_ctrl(`SPW_CODE_EEP, 1'b1, {EV_PEND, `SPW_FLAG_EEP});
			4: send_null();
			default:
			begin
				// A repeated time code would leave no trace
				if (rand_byte == last_tc)
					rand_byte = rand_byte + 8'd1;
				last_tc = rand_byte;
				send_ctrl(`SPW_CODE_ESC, 1'b0, 12'd0);
				send_char(1'b0, rand_byte, 1'b1, {EV_TIMEC, 1'b0, rand_byte});
			end
			endcase
		end
		// Closing NULL, then room for any late pulse
		send_null();
		repeat (20) @(negedge posedge_clk);
		stim_done = 1'b1;
	end

	// Run end
	initial
	begin
		wait_cycles = 0;
		while (!check_done && wait_cycles < 20000)
		begin
			@(negedge posedge_clk);
			wait_cycles = wait_cycles + 1;
		end
		if (!check_done)
			$display("Timeout: checker did not finish within 20000 cycles");
		if (check_done && fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
hw/spw_char_pkg.sv
hw/spw_rx_pkg.sv
hw/spw_char_if.sv
hw/rx_ds_decoder.sv
hw/rx_char_assembler.sv
hw/rx_data_receive.sv
hw/spw_rx_top.sv
tests/spw_rx_checker.sv
tests/tb_spw_rx.sv
